//--- id_pkg.sv
// rv64i decode types only; assumes aligned memory accesses; compressed, fence and ecall are illegal
package id_pkg;

	localparam int xlen = 64; // integer register and data width

	// instruction field positions
	localparam int opcode_lsb     = 0;
	localparam int rd_lsb         = 7;
	localparam int func3_lsb      = 12;
	localparam int rs1_lsb        = 15;
	localparam int rs2_lsb        = 20;
	localparam int funct7_alt_bit = 30; // sub / sra select

	typedef enum logic [6:0] {
		op_imm   = 7'b0010011,
		op_imm32 = 7'b0011011,
		op       = 7'b0110011,
		op32     = 7'b0111011,
		lui      = 7'b0110111,
		auipc    = 7'b0010111,
		jal      = 7'b1101111,
		jalr     = 7'b1100111,
		branch   = 7'b1100011,
		load     = 7'b0000011,
		store    = 7'b0100011,
		system   = 7'b1110011  // csr forms only
	} opcode_e;

	// alu opcode, zero means no operation
	typedef enum logic [4:0] {
		alu_zero, alu_add, alu_slt, alu_sltu, alu_xor, alu_or, alu_and,
		alu_sll, alu_srl, alu_sra, alu_sub,
		alu_lui,  // result is the immediate
		alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
		alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw
	} alu_op_e;

	typedef enum logic [1:0] {
		op2_reg = 2'd0, // rs2 value
		op2_imm = 2'd1, // immediate
		op2_4   = 2'd2  // link address offset
	} op2_src_e;

	// same code as func3[1:0] of the csr instructions
	typedef enum logic [1:0] {
		csr_none = 2'd0,
		csr_rw   = 2'd1,
		csr_rs   = 2'd2,
		csr_rc   = 2'd3
	} csr_op_e;

	typedef struct packed {
		logic [4:0] rs1_addr;
		logic       rs1_en;
		logic [4:0] rs2_addr;
		logic       rs2_en;
		logic [4:0] rd_addr;
		logic       rd_en;
	} reg_ctrl_t;

	typedef struct packed {
		alu_op_e         alu_op;
		logic            op1_pc;      // 1 selects pc
		op2_src_e        op2_src;
		logic [xlen-1:0] imm;
		logic            branch;
		logic            jump;
		logic            pc_from_reg; // jalr target from rs1
	} exe_ctrl_t;

	typedef struct packed {
		logic              mem_rd;
		logic              mem_wr;
		logic [xlen/8-1:0] byte_en;
		logic              mem_unsigned; // zero extend load data
		logic              mem_to_reg;
	} mem_ctrl_t;

	typedef struct packed {
		logic    csr_rd;
		logic    csr_wr;
		csr_op_e csr_op;
	} csr_ctrl_t;

	typedef struct packed {
		reg_ctrl_t reg_ctrl;
		exe_ctrl_t exe_ctrl;
		mem_ctrl_t mem_ctrl;
		csr_ctrl_t csr_ctrl;
	} decode_pkt_t;

	// opcode and func3 combination is one of the kept rv64i forms
	function automatic logic is_legal(input logic [31:0] inst);
		logic [2:0] f3;
		f3 = inst[func3_lsb +: 3];
		case (opcode_e'(inst[opcode_lsb +: 7]))
			op_imm, op, lui, auipc, jal: is_legal = 1'b1;
			op_imm32, op32: is_legal = (f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101);
			jalr:    is_legal = (f3 == 3'b000);
			branch:  is_legal = (f3[2:1] != 2'b01); // 010 and 011 unused
			load:    is_legal = (f3 != 3'b111);
			store:   is_legal = !f3[2];
			system:  is_legal = (f3[1:0] != 2'b00); // no ecall / ebreak
			default: is_legal = 1'b0;
		endcase
	endfunction

endpackage

//--- operand_decode.sv
// register fields, enables and immediate of one instruction; combinational, illegal words give zero
`timescale 1ns/100ps

module operand_decode import id_pkg::*; (
	input  logic [31:0]     inst,
	output reg_ctrl_t       reg_ctrl,
	output logic [xlen-1:0] imm,
	output logic            rs1_nz,
	output logic            rd_nz
);

	opcode_e         opc;
	logic [2:0]      func3;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic            legal;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	assign opc   = opcode_e'(inst[opcode_lsb +: 7]);
	assign func3 = inst[func3_lsb +: 3];
	assign rs1   = inst[rs1_lsb +: 5]; // also the csr uimm
	assign rs2   = inst[rs2_lsb +: 5];
	assign rd    = inst[rd_lsb +: 5];
	assign legal = is_legal(inst);

	assign rs1_nz = |rs1;
	assign rd_nz  = |rd;

	// all immediates sign extended from inst[31]
	assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		reg_ctrl.rs1_addr = rs1; // addresses pass through, enables qualify them
		reg_ctrl.rs2_addr = rs2;
		reg_ctrl.rd_addr  = rd;
		reg_ctrl.rs1_en   = 1'b0;
		reg_ctrl.rs2_en   = 1'b0;
		reg_ctrl.rd_en    = 1'b0;
		imm               = '0;
		if (legal) begin
			case (opc)
				lui, auipc: begin
					imm            = imm_u;
					reg_ctrl.rd_en = 1'b1;
				end
				jal: begin
					imm            = imm_j;
					reg_ctrl.rd_en = 1'b1; // link
				end
				jalr, load, op_imm, op_imm32: begin
					imm             = imm_i;
					reg_ctrl.rs1_en = 1'b1;
					reg_ctrl.rd_en  = 1'b1;
				end
				branch: begin
					imm             = imm_b;
					reg_ctrl.rs1_en = 1'b1;
					reg_ctrl.rs2_en = 1'b1;
				end
				store: begin
					imm             = imm_s;
					reg_ctrl.rs1_en = 1'b1;
					reg_ctrl.rs2_en = 1'b1; // store data
				end
				op, op32: begin
					imm             = imm_i; // unused by the alu
					reg_ctrl.rs1_en = 1'b1;
					reg_ctrl.rs2_en = 1'b1;
					reg_ctrl.rd_en  = 1'b1;
				end
				system: begin
					imm = imm_i; // csr address rides on the imm bus
					// immediate forms (func3[2]) carry uimm, not a register
					reg_ctrl.rs1_en = !func3[2] && ((csr_op_e'(func3[1:0]) == csr_rw) || rs1_nz);
					// rw forms with rd zero skip the old value
					reg_ctrl.rd_en  = (csr_op_e'(func3[1:0]) != csr_rw) || rd_nz;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- control_decode.sv
// alu, operand select, branch, memory and csr controls; combinational, byte_en assumes aligned access
`timescale 1ns/100ps

module control_decode import id_pkg::*; (
	input  logic [31:0] inst,
	input  logic        rs1_nz,   // from operand_decode, rs1 or uimm nonzero
	input  logic        rd_nz,
	output alu_op_e     alu_op,
	output logic        op1_pc,
	output op2_src_e    op2_src,
	output logic        branch,
	output logic        jump,
	output logic        pc_from_reg,
	output mem_ctrl_t   mem_ctrl,
	output csr_ctrl_t   csr_ctrl
);

	opcode_e    opc;
	logic [2:0] func3;
	logic       alt;
	logic       legal;

	assign opc   = opcode_e'(inst[opcode_lsb +: 7]);
	assign func3 = inst[func3_lsb +: 3];
	assign alt   = inst[funct7_alt_bit];
	assign legal = is_legal(inst);

	// 64-bit integer ops, shared by op and op_imm
	function automatic alu_op_e int_alu(input logic [2:0] f3, input logic a, input logic reg_form);
		case (f3)
			3'b000:  int_alu = (a && reg_form) ? alu_sub : alu_add; // addi has no sub
			3'b001:  int_alu = alu_sll;
			3'b010:  int_alu = alu_slt;
			3'b011:  int_alu = alu_sltu;
			3'b100:  int_alu = alu_xor;
			3'b101:  int_alu = a ? alu_sra : alu_srl;
			3'b110:  int_alu = alu_or;
			default: int_alu = alu_and;
		endcase
	endfunction

	// 32-bit w ops, shared by op32 and op_imm32
	function automatic alu_op_e word_alu(input logic [2:0] f3, input logic a, input logic reg_form);
		case (f3)
			3'b000:  word_alu = (a && reg_form) ? alu_subw : alu_addw;
			3'b001:  word_alu = alu_sllw;
			3'b101:  word_alu = a ? alu_sraw : alu_srlw;
			default: word_alu = alu_zero;
		endcase
	endfunction

	// access size 1, 2, 4 or 8 bytes from low lane
	function automatic logic [xlen/8-1:0] size_mask(input logic [1:0] sz);
		logic [xlen/8-1:0] mask;
		mask = '0;
		for (int i = 0; i < xlen/8; i++) begin
			mask[i] = (i < (1 << sz));
		end
		size_mask = mask;
	endfunction

	always_comb begin
		alu_op      = alu_zero;
		op1_pc      = 1'b0;
		op2_src     = op2_reg;
		branch      = 1'b0;
		jump        = 1'b0;
		pc_from_reg = 1'b0;
		mem_ctrl    = '0;
		csr_ctrl    = '0; // csr_none
		if (legal) begin
			case (opc)
				op_imm: begin
					alu_op  = int_alu(func3, alt, 1'b0);
					op2_src = op2_imm;
				end
				op:       alu_op = int_alu(func3, alt, 1'b1);
				op_imm32: begin
					alu_op  = word_alu(func3, alt, 1'b0);
					op2_src = op2_imm;
				end
				op32:     alu_op = word_alu(func3, alt, 1'b1);
				lui: begin
					alu_op  = alu_lui;
					op2_src = op2_imm;
				end
				auipc: begin
					alu_op  = alu_add; // pc + imm_u
					op1_pc  = 1'b1;
					op2_src = op2_imm;
				end
				jal, jalr: begin
					alu_op      = alu_add; // rd gets pc + 4
					op1_pc      = 1'b1;
					op2_src     = op2_4;
					jump        = 1'b1;
					pc_from_reg = (opc == jalr);
				end
				id_pkg::branch: begin
					branch = 1'b1;
					case (func3)
						3'b000:  alu_op = alu_beq;
						3'b001:  alu_op = alu_bne;
						3'b100:  alu_op = alu_blt;
						3'b101:  alu_op = alu_bge;
						3'b110:  alu_op = alu_bltu;
						default: alu_op = alu_bgeu;
					endcase
				end
				load: begin
					alu_op                = alu_add; // address rs1 + imm
					op2_src               = op2_imm;
					mem_ctrl.mem_rd       = 1'b1;
					mem_ctrl.mem_to_reg   = 1'b1;
					mem_ctrl.byte_en      = size_mask(func3[1:0]);
					mem_ctrl.mem_unsigned = func3[2]; // lbu lhu lwu
				end
				store: begin
					alu_op           = alu_add;
					op2_src          = op2_imm;
					mem_ctrl.mem_wr  = 1'b1;
					mem_ctrl.byte_en = size_mask(func3[1:0]);
				end
				system: begin
					alu_op          = alu_lui; // pass operand straight through
					op2_src         = op2_imm;
					csr_ctrl.csr_op = csr_op_e'(func3[1:0]);
					if (csr_op_e'(func3[1:0]) == csr_rw) begin
						csr_ctrl.csr_rd = rd_nz; // no read side effect when rd is x0
						csr_ctrl.csr_wr = 1'b1;
					end else begin
						csr_ctrl.csr_rd = 1'b1;
						csr_ctrl.csr_wr = rs1_nz; // set/clear with zero leaves csr alone
					end
				end
				default: ;
			endcase
		end
	end

endmodule

//--- decode_issue.sv
// in-order packet queue with credit flow both sides; upstream must never write a full queue
`timescale 1ns/100ps

module decode_issue import id_pkg::*; #(
	parameter int queue_depth = 4,
	parameter int out_credits = 2
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            wr_en,
	input  reg_ctrl_t       reg_ctrl,
	input  logic [xlen-1:0] imm,
	input  alu_op_e         alu_op,
	input  logic            op1_pc,
	input  op2_src_e        op2_src,
	input  logic            branch,
	input  logic            jump,
	input  logic            pc_from_reg,
	input  mem_ctrl_t       mem_ctrl,
	input  csr_ctrl_t       csr_ctrl,
	output logic            in_credit,
	output logic            out_valid,
	output decode_pkt_t     out_pkt,
	input  logic            out_credit
);

	localparam int ptr_w  = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w  = $clog2(queue_depth + 1);
	localparam int cred_w = (out_credits > 0) ? $clog2(out_credits + 1) : 1;

	decode_pkt_t       q_mem [queue_depth];
	decode_pkt_t       wr_pkt;
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;   // occupied slots
	logic [cred_w-1:0] credits; // downstream slots we may fill
	logic              deq;

	// merge both decoder halves
	assign wr_pkt.reg_ctrl             = reg_ctrl;
	assign wr_pkt.exe_ctrl.alu_op      = alu_op;
	assign wr_pkt.exe_ctrl.op1_pc      = op1_pc;
	assign wr_pkt.exe_ctrl.op2_src     = op2_src;
	assign wr_pkt.exe_ctrl.imm         = imm;
	assign wr_pkt.exe_ctrl.branch      = branch;
	assign wr_pkt.exe_ctrl.jump        = jump;
	assign wr_pkt.exe_ctrl.pc_from_reg = pc_from_reg;
	assign wr_pkt.mem_ctrl             = mem_ctrl;
	assign wr_pkt.csr_ctrl             = csr_ctrl;

	assign deq       = (count != '0) && (credits != '0); // head leaves every valid cycle
	assign out_valid = deq;
	assign out_pkt   = q_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			q_mem[wr_ptr] <= wr_pkt;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= cred_w'(out_credits); // initial downstream grant
			in_credit <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (deq) begin
				rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count     <= count + cnt_w'(wr_en) - cnt_w'(deq);
			credits   <= credits + cred_w'(out_credit) - cred_w'(deq);
			in_credit <= deq; // slot freed, hand one credit back upstream
		end
	end

endmodule

//--- id_stage.sv
// rv64i decode stage top; upstream starts with queue_depth credits, downstream grants out_credits
`timescale 1ns/100ps

module id_stage import id_pkg::*; #(
	parameter int queue_depth = 4,
	parameter int out_credits = 2
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        inst_valid,
	input  logic [31:0] inst,
	output logic        in_credit,
	output logic        out_valid,
	output decode_pkt_t out_pkt,
	input  logic        out_credit
);

	reg_ctrl_t       reg_ctrl;
	logic [xlen-1:0] imm;
	logic            rs1_nz;
	logic            rd_nz;
	alu_op_e         alu_op;
	logic            op1_pc;
	op2_src_e        op2_src;
	logic            branch;
	logic            jump;
	logic            pc_from_reg;
	mem_ctrl_t       mem_ctrl;
	csr_ctrl_t       csr_ctrl;

	operand_decode u_operand_decode (
		.inst     (inst),
		.reg_ctrl (reg_ctrl),
		.imm      (imm),
		.rs1_nz   (rs1_nz),
		.rd_nz    (rd_nz)
	);

	control_decode u_control_decode (
		.inst        (inst),
		.rs1_nz      (rs1_nz), // nonzero tests live in operand_decode only
		.rd_nz       (rd_nz),
		.alu_op      (alu_op),
		.op1_pc      (op1_pc),
		.op2_src     (op2_src),
		.branch      (branch),
		.jump        (jump),
		.pc_from_reg (pc_from_reg),
		.mem_ctrl    (mem_ctrl),
		.csr_ctrl    (csr_ctrl)
	);

	decode_issue #(
		.queue_depth (queue_depth),
		.out_credits (out_credits)
	) u_decode_issue (
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_en       (inst_valid),
		.reg_ctrl    (reg_ctrl),
		.imm         (imm),
		.alu_op      (alu_op),
		.op1_pc      (op1_pc),
		.op2_src     (op2_src),
		.branch      (branch),
		.jump        (jump),
		.pc_from_reg (pc_from_reg),
		.mem_ctrl    (mem_ctrl),
		.csr_ctrl    (csr_ctrl),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.out_pkt     (out_pkt),
		.out_credit  (out_credit)
	);

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset only; reset is released 1 ns after the last held rising edge
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int period     = 20, // ns
	parameter int rst_cycles = 2
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0; // asserted from time zero
		repeat (rst_cycles) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

//--- tb_decode_model.svh
// reference rv64i decode and random instruction builder; include inside a module that declares seed
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// sign extend the low w bits of v
function automatic logic [xlen-1:0] sign_ext(input logic [xlen-1:0] v, input int w);
	sign_ext = $signed(v << (xlen - w)) >>> (xlen - w);
endfunction

// kept opcode and func3 pairs
function automatic logic form_is_legal(input logic [31:0] w);
	logic [2:0] f3;
	f3 = w[14:12];
	case (w[6:0])
		op_imm, op, lui, auipc, jal: form_is_legal = 1'b1;
		op_imm32, op32: form_is_legal = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
		jalr:    form_is_legal = (f3 == 3'd0);
		branch:  form_is_legal = (f3 != 3'd2) && (f3 != 3'd3);
		load:    form_is_legal = (f3 != 3'd7); // ld is legal in rv64
		store:   form_is_legal = (f3 < 3'd4);
		system:  form_is_legal = (f3 != 3'd0) && (f3 != 3'd4);
		default: form_is_legal = 1'b0;
	endcase
endfunction

function automatic alu_op_e alu_for(input logic [31:0] w);
	logic [2:0] f3;
	logic       sub_ok; // only register forms subtract
	f3     = w[14:12];
	sub_ok = w[30] && ((w[6:0] == op) || (w[6:0] == op32));
	alu_for = alu_zero;
	case (w[6:0])
		op, op_imm: begin
			case (f3)
				3'd0:    alu_for = sub_ok ? alu_sub : alu_add;
				3'd1:    alu_for = alu_sll;
				3'd2:    alu_for = alu_slt;
				3'd3:    alu_for = alu_sltu;
				3'd4:    alu_for = alu_xor;
				3'd5:    alu_for = w[30] ? alu_sra : alu_srl; // srai too
				3'd6:    alu_for = alu_or;
				default: alu_for = alu_and;
			endcase
		end
		op32, op_imm32: begin
			case (f3)
				3'd0:    alu_for = sub_ok ? alu_subw : alu_addw;
				3'd1:    alu_for = alu_sllw;
				3'd5:    alu_for = w[30] ? alu_sraw : alu_srlw;
				default: alu_for = alu_zero;
			endcase
		end
		branch: begin
			case (f3)
				3'd0:    alu_for = alu_beq;
				3'd1:    alu_for = alu_bne;
				3'd4:    alu_for = alu_blt;
				3'd5:    alu_for = alu_bge;
				3'd6:    alu_for = alu_bltu;
				default: alu_for = alu_bgeu;
			endcase
		end
		lui, system: alu_for = alu_lui;
		default:     alu_for = alu_add; // auipc, jal, jalr, load, store
	endcase
endfunction

function automatic decode_pkt_t expected_pkt(input logic [31:0] w);
	decode_pkt_t p;
	logic [6:0]  opc;
	logic [2:0]  f3;
	logic        rw_form; // csrrw or csrrwi
	p       = '0;
	opc     = w[6:0];
	f3      = w[14:12];
	rw_form = (f3[1:0] == 2'd1);
	p.reg_ctrl.rs1_addr = w[19:15]; // fields always pass through
	p.reg_ctrl.rs2_addr = w[24:20];
	p.reg_ctrl.rd_addr  = w[11:7];
	if (form_is_legal(w)) begin
		p.exe_ctrl.alu_op = alu_for(w);
		case (opc)
			lui, auipc: p.exe_ctrl.imm = sign_ext(xlen'({w[31:12], 12'b0}), 32);
			jal: p.exe_ctrl.imm = sign_ext(xlen'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
			branch: p.exe_ctrl.imm = sign_ext(xlen'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
			store: p.exe_ctrl.imm = sign_ext(xlen'({w[31:25], w[11:7]}), 12);
			default: p.exe_ctrl.imm = sign_ext(xlen'(w[31:20]), 12);
		endcase
		p.reg_ctrl.rs1_en = opc inside {jalr, branch, op_imm, op_imm32, op, op32, load, store};
		p.reg_ctrl.rs2_en = opc inside {branch, store, op, op32};
		p.reg_ctrl.rd_en  = !(opc inside {branch, store});
		p.exe_ctrl.op1_pc = opc inside {auipc, jal, jalr};
		if (opc inside {jal, jalr}) begin
			p.exe_ctrl.op2_src = op2_4;
		end else if (opc inside {op, op32, branch}) begin
			p.exe_ctrl.op2_src = op2_reg;
		end else begin
			p.exe_ctrl.op2_src = op2_imm;
		end
		p.exe_ctrl.branch      = (opc == branch);
		p.exe_ctrl.jump        = opc inside {jal, jalr};
		p.exe_ctrl.pc_from_reg = (opc == jalr);
		if ((opc == load) || (opc == store)) begin
			case (f3[1:0])
				2'd0:    p.mem_ctrl.byte_en = 8'h01;
				2'd1:    p.mem_ctrl.byte_en = 8'h03;
				2'd2:    p.mem_ctrl.byte_en = 8'h0f;
				default: p.mem_ctrl.byte_en = 8'hff;
			endcase
			p.mem_ctrl.mem_rd       = (opc == load);
			p.mem_ctrl.mem_wr       = (opc == store);
			p.mem_ctrl.mem_to_reg   = (opc == load);
			p.mem_ctrl.mem_unsigned = (opc == load) && f3[2]; // lbu lhu lwu
		end
		if (opc == system) begin
			p.reg_ctrl.rs1_en = !f3[2] && (rw_form || (w[19:15] != 5'd0));
			p.reg_ctrl.rd_en  = !rw_form || (w[11:7] != 5'd0);
			p.csr_ctrl.csr_op = csr_op_e'(f3[1:0]);
			p.csr_ctrl.csr_rd = rw_form ? (w[11:7] != 5'd0) : 1'b1;
			p.csr_ctrl.csr_wr = rw_form ? 1'b1 : (w[19:15] != 5'd0);
		end
	end
	expected_pkt = p;
endfunction

// one word of class cls, 12 and up is an illegal form
function automatic logic [31:0] random_inst(input int cls);
	logic [31:0] r;
	logic [31:0] m;
	logic [31:0] k3;
	logic [31:0] k6;
	logic [2:0]  w_f3; // w ops
	logic [2:0]  b_f3; // branches
	logic [2:0]  c_f3; // csr forms
	r    = $random(seed);
	m    = $random(seed);
	k3   = (m >> 8) % 3;
	k6   = (m >> 8) % 6;
	w_f3 = (k3 == 0) ? 3'd0 : (k3 == 1) ? 3'd1 : 3'd5;
	b_f3 = (k6 < 2) ? k6[2:0] : k6[2:0] + 3'd2;
	c_f3 = (k6 < 3) ? k6[2:0] + 3'd1 : k6[2:0] + 3'd2;
	case (cls)
		0:  random_inst = {r[31:7], op_imm};
		1:  random_inst = {r[31:15], w_f3, r[11:7], op_imm32};
		2:  random_inst = {1'b0, r[30], 5'b0, r[24:7], op}; // funct7 0 or 0x20
		3:  random_inst = {1'b0, r[30], 5'b0, r[24:15], w_f3, r[11:7], op32};
		4:  random_inst = {r[31:7], lui};
		5:  random_inst = {r[31:7], auipc};
		6:  random_inst = {r[31:7], jal};
		7:  random_inst = {r[31:15], 3'd0, r[11:7], jalr};
		8:  random_inst = {r[31:15], b_f3, r[11:7], branch};
		9:  random_inst = {r[31:15], (m[2:0] == 3'd7) ? 3'd3 : m[2:0], r[11:7], load};
		10: random_inst = {r[31:15], 1'b0, m[1:0], r[11:7], store};
		11: random_inst = {r[31:20], m[3] ? 5'd0 : r[19:15], c_f3, m[4] ? 5'd0 : r[11:7], system};
		default: random_inst = m[5] ? {r[31:7], 7'b0001011} : {r[31:15], 3'd2, r[11:7], op_imm32};
	endcase
endfunction

`endif

//--- tb_id_stage.sv
// random decode test with credit flow on both sides; fixed seed and a stop at the first mismatch
`timescale 1ns/100ps

module tb_id_stage import id_pkg::*; ();

	localparam int num_inst   = 2000;
	localparam int q_depth    = 4;
	localparam int o_credits  = 2;
	localparam int clk_period = 20;

	logic        clk;
	logic        arst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic        in_credit;
	logic        out_valid;
	decode_pkt_t out_pkt;
	logic        out_credit;

	integer      seed = 32'ha85a;
	decode_pkt_t pkt_q [$];        // expected packets in send order
	logic [31:0] word_q [$];       // words behind them
	int          sent = 0;
	int          delivered = 0;
	int          up_credits = q_depth; // upstream credits in hand
	int          in_seen = 0;      // in_credit pulses
	int          returned = 0;     // out_credit pulses
	int          held = 0;         // packets downstream still holds
	logic        last_out_valid = 1'b0; // dequeue seen at the previous sample

	`include "tb_decode_model.svh"

	tb_clk_gen #(.period(clk_period), .rst_cycles(2)) u_clk_gen (.clk(clk), .arst_n(arst_n));

	id_stage #(
		.queue_depth (q_depth),
		.out_credits (o_credits)
	) DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_credit (out_credit)
	);

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic check_field(input string name, input logic [127:0] got, input logic [127:0] want);
		assert (got === want) else
			stop_with_fail($sformatf("** Error %s got 0x%h expected 0x%h", name, got, want));
	endtask

	task automatic compare_pkt(input logic [31:0] w, input decode_pkt_t want);
		check_field($sformatf("out_pkt.reg_ctrl (inst 0x%h)", w),
			128'(out_pkt.reg_ctrl), 128'(want.reg_ctrl));
		check_field($sformatf("out_pkt.exe_ctrl (inst 0x%h)", w),
			128'(out_pkt.exe_ctrl), 128'(want.exe_ctrl));
		check_field($sformatf("out_pkt.mem_ctrl (inst 0x%h)", w),
			128'(out_pkt.mem_ctrl), 128'(want.mem_ctrl));
		check_field($sformatf("out_pkt.csr_ctrl (inst 0x%h)", w),
			128'(out_pkt.csr_ctrl), 128'(want.csr_ctrl));
	endtask

	// sample mid cycle where outputs have settled
	always @(negedge clk) begin
		if (arst_n) begin
			if (sent == 0) begin
				assert (!out_valid && !in_credit) else
					stop_with_fail("out_valid or in_credit went high before any instruction");
			end
			assert (in_credit === last_out_valid) else
				stop_with_fail("in_credit did not pulse exactly one cycle after a packet left");
			if (in_credit) begin
				in_seen++;
				up_credits++;
			end
			if (out_valid) begin
				assert (delivered < o_credits + returned) else
					stop_with_fail("out_valid with no downstream credit left");
				assert (pkt_q.size() != 0) else stop_with_fail("out_valid with nothing outstanding");
				compare_pkt(word_q.pop_front(), pkt_q.pop_front()); // order check too
				delivered++;
				held++;
			end
			last_out_valid = out_valid;
			if (out_credit) begin
				returned++; // usable from the next cycle
			end
		end
	end

	initial begin : stimulus
		int stall;
		inst_valid = 1'b0;
		inst       = '0;
		out_credit = 1'b0;
		stall      = 0;
		wait (arst_n === 1'b1);
		repeat (3) @(posedge clk); // outputs must stay low while idle
		while (delivered < num_inst) begin
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
			out_credit = 1'b0;
			if ((sent < num_inst) && (up_credits > 0) && (($random(seed) & 3) != 0)) begin
				inst       = random_inst(int'($unsigned($random(seed)) % 13));
				inst_valid = 1'b1;
				pkt_q.push_back(expected_pkt(inst));
				word_q.push_back(inst);
				sent++;
				up_credits--;
			end
			// downstream frees slots or withholds them for a stretch
			if (stall > 0) begin
				stall--;
			end else if (($random(seed) & 31) == 0) begin
				stall = 5 + int'($unsigned($random(seed)) % 32);
			end else if ((held > 0) && (($random(seed) & 1) != 0)) begin
				out_credit = 1'b1;
				held--;
			end
		end
		@(posedge clk);
		#1;
		out_credit = 1'b0;
		repeat (3) @(posedge clk); // last in_credit pulse
		if ((in_seen == num_inst) && (sent == num_inst) && (pkt_q.size() == 0)) begin
			$display("sim passed");
			$finish;
		end else begin
			stop_with_fail("instructions or credits missing at the end of the run");
		end
	end

	initial begin : watchdog
		#(num_inst * clk_period * 10);
		stop_with_fail("timeout, the run did not finish and the DUT looks stalled");
	end

endmodule

//--- build.f
+incdir+.
id_pkg.sv
operand_decode.sv
control_decode.sv
decode_issue.sv
id_stage.sv
tb_clk_gen.sv
tb_id_stage.sv

//--- Makefile
# Verilator flow for the decode stage; any variable can be set on the command line

VERILATOR ?= verilator
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_$(TB_TOP)
VFLAGS    ?= --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
